/* nunchuk_macros.svh */
`ifndef NUNCHUK_MACROS_SVH
`define NUNCHUK_MACROS_SVH

// 7-bit I2C address of the controller.
`define NUNCHUK_ADDR 7'h52

// clocks per quarter of one SCL bit period.
// A full bit takes four quarters, so the SCL rate is clk / (4 * this value).
`define I2C_QUARTER_CYCLES 4

// idle clocks between two transactions on the bus.
`define NUNCHUK_POLL_CYCLES 2000

// bytes in one controller report.
`define NUNCHUK_REPORT_BYTES 6

`endif

/* nunchuk_pkg.sv */
package nunchuk_pkg;

	// byte-level commands accepted by the command engine.
	typedef enum logic [2:0] {
		cmd_start,
		cmd_stop,
		cmd_write,
		cmd_read_ack,
		cmd_read_nack
	} i2c_cmd_e;

	// single bus operations performed by the bit engine.
	typedef enum logic [1:0] {
		op_start,
		op_stop,
		op_write,
		op_read
	} bit_op_e;

	typedef enum logic [2:0] {
		init1,          // write F0 55.
		init2,          // write FB 00.
		pointer_write,  // register pointer back to 0x00.
		read_report,
		wait_poll
	} seq_state_e;

	// byte 0 of the report sits in the top bits because it arrives first on the wire.
	typedef struct packed {
		logic [7:0] joy_x;
		logic [7:0] joy_y;
		logic [7:0] accel_x_hi;
		logic [7:0] accel_y_hi;
		logic [7:0] accel_z_hi;
		logic [1:0] accel_z_lo;
		logic [1:0] accel_y_lo;
		logic [1:0] accel_x_lo;
		logic c_n;  // buttons read 0 when pressed.
		logic z_n;
	} nunchuk_fields_t;

	typedef union packed {
		logic [0:5][7:0] bytes;
		nunchuk_fields_t fields;
	} nunchuk_report_u;

endpackage

/* i2c_bit_engine.sv */
`include "nunchuk_macros.svh"

module i2c_bit_engine (
	input logic clk,
	input logic rst_n,
	input logic sda_in,
	input nunchuk_pkg::bit_op_e bit_op,
	input logic bit_wdata,
	input logic bit_go,
	output logic bit_busy,
	output logic bit_done,
	output logic bit_rdata,
	output logic scl_o,
	output logic sda_oe
);

	localparam int Q = `I2C_QUARTER_CYCLES;
	localparam int QW = $clog2(Q + 1);

	nunchuk_pkg::bit_op_e op_q;
	logic wdata_q;
	logic [QW-1:0] q_cnt;
	logic [1:0] phase;
	logic sda_meta;
	logic sda_sync;
	logic last_quarter;

	// line levels {scl, sda_oe} for one quarter of an operation.
	function automatic logic [1:0] phase_lines(nunchuk_pkg::bit_op_e op, logic [1:0] ph,
			logic wd);
		logic scl_high;
		logic [1:0] r;
		scl_high = (ph == 2'd1) || (ph == 2'd2);
		case (op)
			nunchuk_pkg::op_start: begin
				// sda is pulled low in the third quarter while scl is still high.
				if (ph == 2'd3)
					r = 2'b01;
				else if (ph == 2'd2)
					r = 2'b11;
				else
					r = 2'b10;
			end
			nunchuk_pkg::op_stop: begin
				if (ph == 2'd0)
					r = 2'b01;
				else if (ph == 2'd1)
					r = 2'b11;
				else
					r = 2'b10; // released with scl high.
			end
			nunchuk_pkg::op_write: r = {scl_high, ~wd};
			default: r = {scl_high, 1'b0};
		endcase
		return r;
	endfunction

	assign last_quarter = (q_cnt == QW'(Q - 1));
	assign bit_done = bit_busy && (phase == 2'd3) && last_quarter;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sda_meta <= 1'b1;
			sda_sync <= 1'b1;
		end else begin
			sda_meta <= sda_in;
			sda_sync <= sda_meta;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			op_q <= nunchuk_pkg::op_start;
			wdata_q <= 1'b1;
			q_cnt <= '0;
			phase <= 2'd0;
			bit_busy <= 1'b0;
			bit_rdata <= 1'b1;
			scl_o <= 1'b1;
			sda_oe <= 1'b0;
		end else if (bit_go && !bit_busy) begin
			op_q <= bit_op;
			wdata_q <= bit_wdata;
			q_cnt <= '0;
			phase <= 2'd0;
			bit_busy <= 1'b1;
			{scl_o, sda_oe} <= phase_lines(bit_op, 2'd0, bit_wdata);
		end else if (bit_busy) begin
			if (last_quarter) begin
				q_cnt <= '0;
				if (phase == 2'd1)
					bit_rdata <= sda_sync; // middle of the scl high time.
				if (phase == 2'd3) begin
					bit_busy <= 1'b0;
				end else begin
					phase <= phase + 2'd1;
					{scl_o, sda_oe} <= phase_lines(op_q, phase + 2'd1, wdata_q);
				end
			end else begin
				q_cnt <= q_cnt + 1'b1;
			end
		end
	end

	// data may only move while scl is low; start and stop are the two exceptions.
	assert property (@(posedge clk) disable iff (!rst_n)
		($changed(sda_oe) && op_q != nunchuk_pkg::op_start && op_q != nunchuk_pkg::op_stop)
			|-> (!scl_o && !$past(scl_o)));

endmodule

/* i2c_command_engine.sv */
module i2c_command_engine (
	input logic clk,
	input logic rst_n,
	input nunchuk_pkg::i2c_cmd_e cmd,
	input logic [7:0] cmd_wdata,
	input logic cmd_go,
	output logic cmd_busy,
	output logic cmd_done,
	output logic [7:0] cmd_rdata,
	output logic cmd_nack,
	output nunchuk_pkg::bit_op_e bit_op,
	output logic bit_wdata,
	output logic bit_go,
	input logic bit_busy,
	input logic bit_done,
	input logic bit_rdata
);

	nunchuk_pkg::i2c_cmd_e cmd_q;
	logic [7:0] sh;
	logic [3:0] bit_cnt;
	logic byte_cmd;
	logic ack_slot;
	logic last_bit;

	assign byte_cmd = (cmd_q != nunchuk_pkg::cmd_start) && (cmd_q != nunchuk_pkg::cmd_stop);
	assign ack_slot = (bit_cnt == 4'd8); // ninth bit of a byte.
	assign last_bit = !byte_cmd || ack_slot;
	assign cmd_rdata = sh;

	always_comb begin
		bit_wdata = 1'b1;
		case (cmd_q)
			nunchuk_pkg::cmd_start: bit_op = nunchuk_pkg::op_start;
			nunchuk_pkg::cmd_stop: bit_op = nunchuk_pkg::op_stop;
			nunchuk_pkg::cmd_write: begin
				// msb first, then release sda so the target can acknowledge.
				bit_op = ack_slot ? nunchuk_pkg::op_read : nunchuk_pkg::op_write;
				bit_wdata = sh[7];
			end
			default: begin
				bit_op = ack_slot ? nunchuk_pkg::op_write : nunchuk_pkg::op_read;
				bit_wdata = (cmd_q == nunchuk_pkg::cmd_read_nack); // nack on the last byte.
			end
		endcase
	end

	// the same register shifts write data out and read data in.
	always_ff @(posedge clk) begin
		if (cmd_go && !cmd_busy)
			sh <= cmd_wdata;
		else if (cmd_busy && bit_done && !last_bit)
			sh <= {sh[6:0], bit_rdata};
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cmd_q <= nunchuk_pkg::cmd_start;
			bit_cnt <= 4'd0;
			cmd_busy <= 1'b0;
			cmd_done <= 1'b0;
			cmd_nack <= 1'b0;
			bit_go <= 1'b0;
		end else begin
			cmd_done <= 1'b0;
			bit_go <= 1'b0;
			if (cmd_go && !cmd_busy) begin
				cmd_q <= cmd;
				bit_cnt <= 4'd0;
				cmd_nack <= 1'b0;
				cmd_busy <= 1'b1;
				bit_go <= 1'b1;
			end else if (cmd_busy && bit_done) begin
				if (last_bit) begin
					cmd_busy <= 1'b0;
					cmd_done <= 1'b1;
					if (cmd_q == nunchuk_pkg::cmd_write)
						cmd_nack <= bit_rdata; // high sda in the ack slot means no target.
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
					bit_go <= 1'b1;
				end
			end
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) bit_go |-> !bit_busy);

endmodule

/* nunchuk_sequencer.sv */
`include "nunchuk_macros.svh"

module nunchuk_sequencer (
	input logic clk,
	input logic rst_n,
	output nunchuk_pkg::i2c_cmd_e cmd,
	output logic [7:0] cmd_wdata,
	output logic cmd_go,
	input logic cmd_busy,
	input logic cmd_done,
	input logic [7:0] cmd_rdata,
	input logic cmd_nack,
	output logic [7:0] joy_x,
	output logic [7:0] joy_y,
	output logic [9:0] accel_x,
	output logic [9:0] accel_y,
	output logic [9:0] accel_z,
	output logic button_c,
	output logic button_z,
	output logic report_valid,
	output logic ack_error
);

	localparam int N = `NUNCHUK_REPORT_BYTES;
	localparam int POLL = `NUNCHUK_POLL_CYCLES;
	localparam int PW = $clog2(POLL + 1);
	localparam logic [7:0] ADDR_W = {`NUNCHUK_ADDR, 1'b0};
	localparam logic [7:0] ADDR_R = {`NUNCHUK_ADDR, 1'b1};

	nunchuk_pkg::seq_state_e state;
	nunchuk_pkg::seq_state_e resume_state;
	nunchuk_pkg::nunchuk_report_u report;
	logic [3:0] step;
	logic [PW-1:0] poll_cnt;
	logic in_flight;
	logic err_q;
	logic read_cmd;

	function automatic nunchuk_pkg::seq_state_e after(nunchuk_pkg::seq_state_e s);
		nunchuk_pkg::seq_state_e n;
		case (s)
			nunchuk_pkg::init1: n = nunchuk_pkg::init2;
			nunchuk_pkg::init2: n = nunchuk_pkg::pointer_write;
			nunchuk_pkg::pointer_write: n = nunchuk_pkg::read_report;
			default: n = nunchuk_pkg::pointer_write;
		endcase
		return n;
	endfunction

	// command for the current step; after a nack only the stop is left.
	always_comb begin
		cmd = nunchuk_pkg::cmd_stop;
		cmd_wdata = 8'h00;
		if (!err_q && state != nunchuk_pkg::wait_poll) begin
			if (step == 4'd0) begin
				cmd = nunchuk_pkg::cmd_start;
			end else if (step == 4'd1) begin
				cmd = nunchuk_pkg::cmd_write;
				cmd_wdata = (state == nunchuk_pkg::read_report) ? ADDR_R : ADDR_W;
			end else begin
				case (state)
					nunchuk_pkg::init1: begin
						if (step <= 4'd3)
							cmd = nunchuk_pkg::cmd_write;
						cmd_wdata = (step == 4'd2) ? 8'hF0 : 8'h55;
					end
					nunchuk_pkg::init2: begin
						if (step <= 4'd3)
							cmd = nunchuk_pkg::cmd_write;
						cmd_wdata = (step == 4'd2) ? 8'hFB : 8'h00;
					end
					nunchuk_pkg::pointer_write: begin
						if (step == 4'd2)
							cmd = nunchuk_pkg::cmd_write;
					end
					default: begin
						if (step <= 4'(N))
							cmd = nunchuk_pkg::cmd_read_ack;
						else if (step == 4'(N + 1))
							cmd = nunchuk_pkg::cmd_read_nack;
					end
				endcase
			end
		end
	end

	assign read_cmd = (cmd == nunchuk_pkg::cmd_read_ack) || (cmd == nunchuk_pkg::cmd_read_nack);

	always_ff @(posedge clk) begin
		if (cmd_done && read_cmd)
			report.bytes <= {report.bytes[1:N-1], cmd_rdata}; // byte 0 ends up on top.
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= nunchuk_pkg::init1;
			resume_state <= nunchuk_pkg::init1;
			step <= 4'd0;
			poll_cnt <= '0;
			in_flight <= 1'b0;
			err_q <= 1'b0;
			cmd_go <= 1'b0;
			report_valid <= 1'b0;
			ack_error <= 1'b0;
			joy_x <= 8'd0;
			joy_y <= 8'd0;
			accel_x <= 10'd0;
			accel_y <= 10'd0;
			accel_z <= 10'd0;
			button_c <= 1'b0;
			button_z <= 1'b0;
		end else begin
			cmd_go <= 1'b0;
			report_valid <= 1'b0;
			ack_error <= 1'b0;
			if (state == nunchuk_pkg::wait_poll) begin
				if (poll_cnt == PW'(POLL - 1)) begin
					state <= resume_state;
					poll_cnt <= '0;
				end else begin
					poll_cnt <= poll_cnt + 1'b1;
				end
			end else if (cmd_done) begin
				in_flight <= 1'b0;
				if (cmd == nunchuk_pkg::cmd_stop) begin
					state <= nunchuk_pkg::wait_poll;
					step <= 4'd0;
					err_q <= 1'b0;
					if (err_q) begin
						ack_error <= 1'b1;
						resume_state <= state; // the same step again after the pause.
					end else begin
						resume_state <= after(state);
						if (state == nunchuk_pkg::read_report) begin
							report_valid <= 1'b1;
							joy_x <= report.fields.joy_x;
							joy_y <= report.fields.joy_y;
							accel_x <= {report.fields.accel_x_hi, report.fields.accel_x_lo};
							accel_y <= {report.fields.accel_y_hi, report.fields.accel_y_lo};
							accel_z <= {report.fields.accel_z_hi, report.fields.accel_z_lo};
							button_c <= ~report.fields.c_n;
							button_z <= ~report.fields.z_n;
						end
					end
				end else if (cmd_nack) begin
					err_q <= 1'b1;
				end else begin
					step <= step + 4'd1;
				end
			end else if (!in_flight && !cmd_busy) begin
				cmd_go <= 1'b1;
				in_flight <= 1'b1;
			end
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) cmd_go |-> !cmd_busy);

endmodule

/* nunchuk_top.sv */
module nunchuk_top (
	input logic clk,
	input logic rst_n,
	output logic scl,
	inout wire sda,
	output logic [7:0] joy_x,
	output logic [7:0] joy_y,
	output logic [9:0] accel_x,
	output logic [9:0] accel_y,
	output logic [9:0] accel_z,
	output logic button_c,
	output logic button_z,
	output logic report_valid,
	output logic ack_error
);

	nunchuk_pkg::i2c_cmd_e cmd;
	logic [7:0] cmd_wdata;
	logic cmd_go;
	logic cmd_busy;
	logic cmd_done;
	logic [7:0] cmd_rdata;
	logic cmd_nack;
	nunchuk_pkg::bit_op_e bit_op;
	logic bit_wdata;
	logic bit_go;
	logic bit_busy;
	logic bit_done;
	logic bit_rdata;
	logic sda_oe;

	assign sda = sda_oe ? 1'b0 : 1'bz; // the pin is only pulled low and the pullup gives the high level.

	nunchuk_sequencer nunchuk_sequencer_inst (
		.clk(clk),
		.rst_n(rst_n),
		.cmd(cmd),
		.cmd_wdata(cmd_wdata),
		.cmd_go(cmd_go),
		.cmd_busy(cmd_busy),
		.cmd_done(cmd_done),
		.cmd_rdata(cmd_rdata),
		.cmd_nack(cmd_nack),
		.joy_x(joy_x),
		.joy_y(joy_y),
		.accel_x(accel_x),
		.accel_y(accel_y),
		.accel_z(accel_z),
		.button_c(button_c),
		.button_z(button_z),
		.report_valid(report_valid),
		.ack_error(ack_error)
	);

	i2c_command_engine i2c_command_engine_inst (
		.clk(clk),
		.rst_n(rst_n),
		.cmd(cmd),
		.cmd_wdata(cmd_wdata),
		.cmd_go(cmd_go),
		.cmd_busy(cmd_busy),
		.cmd_done(cmd_done),
		.cmd_rdata(cmd_rdata),
		.cmd_nack(cmd_nack),
		.bit_op(bit_op),
		.bit_wdata(bit_wdata),
		.bit_go(bit_go),
		.bit_busy(bit_busy),
		.bit_done(bit_done),
		.bit_rdata(bit_rdata)
	);

	i2c_bit_engine i2c_bit_engine_inst (
		.clk(clk),
		.rst_n(rst_n),
		.sda_in(sda),
		.bit_op(bit_op),
		.bit_wdata(bit_wdata),
		.bit_go(bit_go),
		.bit_busy(bit_busy),
		.bit_done(bit_done),
		.bit_rdata(bit_rdata),
		.scl_o(scl),
		.sda_oe(sda_oe)
	);

endmodule

/* nunchuk_model.sv */
`include "nunchuk_macros.svh"

module nunchuk_model (
	input logic scl,
	inout wire sda,
	input logic present,
	input logic [47:0] report,
	output logic [7:0] wr_byte,
	output int wr_count,
	output int rd_count
);

	logic scl_q = 1'b1;
	logic sda_q = 1'b1;
	logic active = 1'b0;
	logic addr_phase = 1'b0;
	logic addressed = 1'b0;
	logic sending = 1'b0;
	logic master_ack = 1'b0;
	logic drive_low = 1'b0;
	logic [7:0] rx = 8'h00;
	logic [7:0] tx = 8'h00;
	logic [7:0] last_wr = 8'h00;
	int bit_cnt = 0;
	int byte_idx = 0;
	int wr_total = 0;
	int rd_total = 0;

	assign sda = drive_low ? 1'b0 : 1'bz;
	assign wr_byte = last_wr;
	assign wr_count = wr_total;
	assign rd_count = rd_total;

	// both lines go through one process so start, stop and scl edges keep their order.
	always @(posedge scl or negedge scl or posedge sda or negedge sda) begin
		if (scl_q === 1'b1 && scl === 1'b1 && sda_q === 1'b1 && sda === 1'b0) begin
			active = 1'b1; // start.
			addr_phase = 1'b1;
			addressed = 1'b0;
			sending = 1'b0;
			bit_cnt = 0;
			drive_low = 1'b0;
		end else if (scl_q === 1'b1 && scl === 1'b1 && sda_q === 1'b0 && sda === 1'b1) begin
			active = 1'b0; // stop.
			sending = 1'b0;
			drive_low = 1'b0;
		end else if (active && scl_q === 1'b0 && scl === 1'b1) begin
			if (bit_cnt < 8)
				rx = {rx[6:0], sda !== 1'b0};
			else
				master_ack = (sda === 1'b0);
			bit_cnt = bit_cnt + 1;
		end else if (active && scl_q === 1'b1 && scl === 1'b0) begin
			if (bit_cnt == 8) begin
				// the acknowledge slot starts here.
				if (addr_phase) begin
					addressed = present && (rx[7:1] == `NUNCHUK_ADDR);
					drive_low = addressed;
				end else if (sending) begin
					drive_low = 1'b0; // the master answers this one.
				end else if (addressed) begin
					last_wr = rx;
					wr_total = wr_total + 1;
					drive_low = 1'b1;
				end
			end else if (bit_cnt == 9) begin
				bit_cnt = 0;
				drive_low = 1'b0;
				if (addr_phase) begin
					addr_phase = 1'b0;
					if (addressed && rx[0]) begin
						sending = 1'b1;
						byte_idx = 0;
						rd_total = rd_total + 1;
					end
				end else if (sending) begin
					if (master_ack && byte_idx < `NUNCHUK_REPORT_BYTES - 1)
						byte_idx = byte_idx + 1;
					else
						sending = 1'b0;
				end
				if (sending) begin
					tx = report[47 - 8 * byte_idx -: 8];
					drive_low = !tx[7];
				end
			end else if (sending) begin
				drive_low = !tx[7 - bit_cnt];
			end
		end
		scl_q = scl;
		sda_q = sda;
	end

endmodule

/* tb_nunchuk_top.sv */
`include "nunchuk_macros.svh"

module tb_nunchuk_top;

	localparam int NUM_TESTS = 6;
	localparam int ABSENT_AT = 3;
	localparam int ABSENT_ERRORS = 2;
	localparam int CLK_PERIOD = 8;
	localparam int BIT_CYCLES = 4 * `I2C_QUARTER_CYCLES + 2;
	localparam int BYTE_CYCLES = 9 * BIT_CYCLES;
	localparam int READ_CYCLES = 2 * BIT_CYCLES + (`NUNCHUK_REPORT_BYTES + 1) * BYTE_CYCLES;
	localparam int POLL_PERIOD = `NUNCHUK_POLL_CYCLES + READ_CYCLES;
	localparam int INIT_CYCLES = 2 * (`NUNCHUK_POLL_CYCLES + 2 * BIT_CYCLES + 3 * BYTE_CYCLES);
	localparam int WAIT_LIMIT = 3 * POLL_PERIOD;
	localparam int WATCHDOG_CYCLES = (NUM_TESTS + ABSENT_ERRORS) * WAIT_LIMIT + INIT_CYCLES + 10;
	localparam logic [7:0] INIT_WRITES [5] = '{8'hF0, 8'h55, 8'hFB, 8'h00, 8'h00};

	logic clk;
	logic rst_n;
	wire scl;
	wire sda;
	logic [7:0] joy_x;
	logic [7:0] joy_y;
	logic [9:0] accel_x;
	logic [9:0] accel_y;
	logic [9:0] accel_z;
	logic button_c;
	logic button_z;
	logic report_valid;
	logic ack_error;
	logic model_present;
	logic [47:0] model_report;
	logic [7:0] wr_byte;
	int wr_count;
	int rd_count;

	logic [47:0] stim_report [NUM_TESTS];
	logic [7:0] exp_joy_x [NUM_TESTS];
	logic [7:0] exp_joy_y [NUM_TESTS];
	logic [9:0] exp_accel_x [NUM_TESTS];
	logic [9:0] exp_accel_y [NUM_TESTS];
	logic [9:0] exp_accel_z [NUM_TESTS];
	logic exp_button_c [NUM_TESTS];
	logic exp_button_z [NUM_TESTS];

	logic [7:0] wr_log [$];
	int read_marks [$]; // write log length at each read start.
	int seen_wr;
	int seen_rd;
	int err_count;
	int pass_count;
	int fail_count;

	pullup (sda);

	nunchuk_top nunchuk_top_inst (
		.clk(clk),
		.rst_n(rst_n),
		.scl(scl),
		.sda(sda),
		.joy_x(joy_x),
		.joy_y(joy_y),
		.accel_x(accel_x),
		.accel_y(accel_y),
		.accel_z(accel_z),
		.button_c(button_c),
		.button_z(button_z),
		.report_valid(report_valid),
		.ack_error(ack_error)
	);

	nunchuk_model nunchuk_model_inst (
		.scl(scl),
		.sda(sda),
		.present(model_present),
		.report(model_report),
		.wr_byte(wr_byte),
		.wr_count(wr_count),
		.rd_count(rd_count)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("sim failed");
		$finish;
	end

	always @(negedge clk) begin
		if (wr_count != seen_wr) begin
			wr_log.push_back(wr_byte);
			seen_wr = wr_count;
		end
		if (rd_count != seen_rd) begin
			read_marks.push_back(wr_log.size());
			seen_rd = rd_count;
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
			err_count++;
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		if (err_count == errs_before) begin
			$display("%s: ok", name);
			pass_count++;
		end else begin
			$display("%s: FAILED", name);
			fail_count++;
		end
	endtask

	// accelerometer low bits and buttons all sit in byte 5.
	task automatic fill_table();
		logic [31:0] r0;
		logic [31:0] r1;
		logic [7:0] low;
		for (int i = 0; i < NUM_TESTS; i++) begin
			r0 = $urandom;
			r1 = $urandom;
			case (i)
				0: stim_report[i] = 48'h80_7f_20_c4_ff_a5;
				1: stim_report[i] = 48'h00_00_00_00_00_00;
				2: stim_report[i] = 48'hff_ff_ff_ff_ff_ff;
				default: stim_report[i] = {r0, r1[15:0]};
			endcase
			low = stim_report[i][7:0];
			exp_joy_x[i] = stim_report[i][47:40];
			exp_joy_y[i] = stim_report[i][39:32];
			exp_accel_x[i] = {stim_report[i][31:24], low[3:2]};
			exp_accel_y[i] = {stim_report[i][23:16], low[5:4]};
			exp_accel_z[i] = {stim_report[i][15:8], low[7:6]};
			exp_button_c[i] = ~low[1];
			exp_button_z[i] = ~low[0];
		end
	endtask

	task automatic wait_pulse(input bit want_error, input int limit, output bit seen);
		int start_rd;
		int n;
		start_rd = rd_count;
		seen = 1'b0;
		n = 0;
		while (!seen && n < limit) begin
			@(negedge clk);
			n++;
			if (want_error) begin
				seen = ack_error;
				if (report_valid) begin
					$display("report_valid pulsed at %0t while the target was absent", $time);
					err_count++;
				end
			end else begin
				seen = report_valid && (rd_count > start_rd);
				if (ack_error) begin
					$display("ack_error pulsed at %0t while the target was present", $time);
					err_count++;
				end
			end
		end
	endtask

	task automatic check_report(input int i);
		check_value("joy_x", 32'(joy_x), 32'(exp_joy_x[i]));
		check_value("joy_y", 32'(joy_y), 32'(exp_joy_y[i]));
		check_value("accel_x", 32'(accel_x), 32'(exp_accel_x[i]));
		check_value("accel_y", 32'(accel_y), 32'(exp_accel_y[i]));
		check_value("accel_z", 32'(accel_z), 32'(exp_accel_z[i]));
		check_value("button_c", 32'(button_c), 32'(exp_button_c[i]));
		check_value("button_z", 32'(button_z), 32'(exp_button_z[i]));
	endtask

	// the first read follows both init writes and a pointer write, later reads one pointer write.
	task automatic check_writes();
		int first;
		int last;
		int n_exp;
		last = read_marks[read_marks.size() - 1];
		first = (read_marks.size() > 1) ? read_marks[read_marks.size() - 2] : 0;
		n_exp = (read_marks.size() == 1) ? 5 : 1;
		check_value("wr_count", 32'(last - first), 32'(n_exp));
		if (last - first == n_exp) begin
			for (int k = 0; k < n_exp; k++)
				check_value("wr_byte", 32'(wr_log[first + k]),
					32'((n_exp == 5) ? INIT_WRITES[k] : 8'h00));
		end
	endtask

	task automatic run_absent_test();
		int errs_before;
		int pulses;
		bit seen;
		errs_before = err_count;
		@(negedge clk);
		model_present = 1'b0;
		pulses = 0;
		seen = 1'b1;
		while (seen && pulses < ABSENT_ERRORS) begin
			wait_pulse(1'b1, WAIT_LIMIT, seen);
			if (seen)
				pulses++;
		end
		if (!seen) begin
			$display("absent target: no ack_error pulse within %0d cycles", WAIT_LIMIT);
			err_count++;
		end
		@(negedge clk);
		model_present = 1'b1;
		report_test("absent target", errs_before);
	endtask

	initial begin
		int errs_before;
		bit seen;
		void'($urandom(32'hd91a_9d77));
		rst_n = 1'b0;
		model_present = 1'b1;
		fill_table();
		model_report = stim_report[0];
		repeat (5) @(posedge clk);
		@(negedge clk);
		errs_before = err_count;
		check_value("scl", 32'(scl), 32'd1);
		check_value("sda", 32'(sda), 32'd1);
		check_value("report_valid", 32'(report_valid), 32'd0);
		check_value("ack_error", 32'(ack_error), 32'd0);
		report_test("reset state", errs_before);
		rst_n = 1'b1;

		for (int i = 0; i < NUM_TESTS; i++) begin
			if (i == ABSENT_AT)
				run_absent_test();
			errs_before = err_count;
			@(negedge clk);
			model_report = stim_report[i]; // loaded while the sequencer waits out the poll.
			wait_pulse(1'b0, (i == 0) ? WAIT_LIMIT + INIT_CYCLES : WAIT_LIMIT, seen);
			if (seen) begin
				check_report(i);
				check_writes();
			end else begin
				$display("report test %0d: no report_valid after a new read", i);
				err_count++;
			end
			report_test($sformatf("report test %0d", i), errs_before);
		end

		$display("%0d tests passed, %0d tests failed, %0d errors",
			pass_count, fail_count, err_count);
		if (err_count == 0 && fail_count == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

/* compile.f */
+incdir+.
nunchuk_pkg.sv
i2c_bit_engine.sv
i2c_command_engine.sv
nunchuk_sequencer.sv
nunchuk_top.sv
nunchuk_model.sv
tb_nunchuk_top.sv

/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module tb_nunchuk_top -f compile.f \
		-Mdir obj_dir -o tb_nunchuk_top

run: compile
	./obj_dir/tb_nunchuk_top > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	@if grep -q "sim failed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
